// ==== flist.f ====
rtl/tagmem_pkg.sv
rtl/write_fifo.sv
rtl/bank_pointers.sv
rtl/access_ctrl.sv
rtl/tx_serializer.sv
rtl/tagmem_top.sv
tb/tb_tagmem.sv

// ==== rtl/access_ctrl.sv ====
// write/read arbiter, four-step memory access FSM and read session tracking
`timescale 1ns/10ps

module access_ctrl (
    input  logic                     clk,
    input  logic                     factory_reset,
    input  logic                     cmd_valid,
    output logic                     busy,
    output logic                     cmd_start,
    input  logic                     epc_empty,
    input  tagmem_pkg::word_t        epc_data,
    output logic                     epc_pop,
    input  logic                     sensor_empty,
    input  tagmem_pkg::sensor_item_t sensor_item,
    output logic                     sensor_pop,
    input  tagmem_pkg::mem_addr_t    epc_wr_addr,
    input  tagmem_pkg::mem_addr_t    s1_wr_addr,
    input  tagmem_pkg::mem_addr_t    s2_wr_addr,
    input  tagmem_pkg::mem_addr_t    read_addr,
    input  tagmem_pkg::bank_sel_t    read_bank,
    input  logic                     read_active,
    input  logic                     read_last,
    output logic                     epc_written,
    output logic                     sensor_written,
    output tagmem_pkg::sensor_id_t   written_sensor,
    output logic                     read_step,
    input  logic                     word_req,
    output logic                     word_load,
    output tagmem_pkg::word_t        word_data,
    output logic                     word_last,
    output logic                     end_mark,
    input  logic                     tx_done,
    output logic                     pc_b,
    output logic                     we,
    output logic                     se,
    output tagmem_pkg::bank_sel_t    mem_sel,
    output tagmem_pkg::mem_addr_t    mem_addr,
    output tagmem_pkg::word_t        mem_write_data,
    input  tagmem_pkg::word_t        mem_read_data
);

    typedef enum logic [2:0] {IDLE, PRECHARGE, ACCESS, LATCH, RELEASE} state_t;
    typedef enum logic [1:0] {OP_EPC_WR, OP_SENSOR_WR, OP_READ} op_t;

    state_t state;
    op_t    op;
    logic   busy_q;      // read session open
    logic   end_sent;
    logic   start_epc;
    logic   start_sensor;
    logic   start_read;

    // epc writes before sensor writes before reads
    assign start_epc    = (state == IDLE) && !epc_empty;
    assign start_sensor = (state == IDLE) && epc_empty && !sensor_empty;
    assign start_read   = (state == IDLE) && epc_empty && sensor_empty && read_active && word_req;

    assign epc_pop    = start_epc;
    assign sensor_pop = start_sensor;
    assign busy       = busy_q && !tx_done;
    assign cmd_start  = cmd_valid && !busy;
    assign end_mark   = busy_q && !end_sent && !read_active && (state == IDLE);

    assign epc_written    = (state == LATCH) && (op == OP_EPC_WR);
    assign sensor_written = (state == LATCH) && (op == OP_SENSOR_WR);
    assign read_step      = (state == LATCH) && (op == OP_READ);
    assign word_load      = read_step;          // memory data valid through LATCH
    assign word_data      = mem_read_data;
    assign word_last      = read_last;

    always_ff @(posedge clk) begin
        if (factory_reset) begin
            state    <= IDLE;
            op       <= OP_READ;
            pc_b     <= 1'b1;
            we       <= 1'b0;
            se       <= 1'b0;
            mem_sel  <= tagmem_pkg::BANK_NONE;
            busy_q   <= 1'b0;
            end_sent <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_epc) begin
                        op      <= OP_EPC_WR;
                        mem_sel <= tagmem_pkg::BANK_EPC;
                    end else if (start_sensor) begin
                        op      <= OP_SENSOR_WR;
                        mem_sel <= (sensor_item.id == tagmem_pkg::SENSOR_1) ?
                                   tagmem_pkg::BANK_SENSOR1 : tagmem_pkg::BANK_SENSOR2;
                    end else if (start_read) begin
                        op      <= OP_READ;
                        mem_sel <= read_bank;
                    end
                    if (start_epc || start_sensor || start_read) begin
                        pc_b  <= 1'b0;     // precharge
                        state <= PRECHARGE;
                    end
                end
                PRECHARGE: begin
                    pc_b  <= 1'b1;
                    we    <= (op != OP_READ);
                    se    <= (op == OP_READ);
                    state <= ACCESS;
                end
                ACCESS:  state <= LATCH;
                LATCH: begin
                    we    <= 1'b0;
                    se    <= 1'b0;
                    state <= RELEASE;
                end
                RELEASE: begin
                    mem_sel <= tagmem_pkg::BANK_NONE;
                    state   <= IDLE;
                end
                default: state <= IDLE;
            endcase

            if (tx_done) busy_q <= 1'b0;
            if (end_mark) end_sent <= 1'b1;
            if (cmd_start) begin    // takes precedence over a closing session
                busy_q   <= 1'b1;
                end_sent <= 1'b0;
            end
        end
    end

    // address and write payload captured as the access starts
    always_ff @(posedge clk) begin
        if (start_epc) begin
            mem_addr       <= epc_wr_addr;
            mem_write_data <= epc_data;
        end else if (start_sensor) begin
            mem_addr       <= (sensor_item.id == tagmem_pkg::SENSOR_1) ? s1_wr_addr : s2_wr_addr;
            mem_write_data <= tagmem_pkg::word_t'(sensor_item.rec);
            written_sensor <= sensor_item.id;
        end else if (start_read) begin
            mem_addr <= read_addr;
        end
    end

    assert property (@(posedge clk) disable iff (factory_reset) !(we && se));

endmodule

// ==== rtl/bank_pointers.sv ====
// fill counters of the three banks with the read cursor and its remaining words
`timescale 1ns/10ps

module bank_pointers #(
    parameter int BANK_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    factory_reset,
    input  logic                    cmd_start,
    input  tagmem_pkg::cmd_op_t     cmd_op,
    input  tagmem_pkg::mem_addr_t   read_ptr,
    input  tagmem_pkg::word_count_t read_words,
    input  tagmem_pkg::sensor_id_t  sensor_id,
    input  logic                    epc_written,
    input  logic                    sensor_written,
    input  tagmem_pkg::sensor_id_t  written_sensor,
    input  logic                    read_step,
    output tagmem_pkg::mem_addr_t   epc_wr_addr,
    output tagmem_pkg::mem_addr_t   s1_wr_addr,
    output tagmem_pkg::mem_addr_t   s2_wr_addr,
    output tagmem_pkg::mem_addr_t   read_addr,
    output tagmem_pkg::bank_sel_t   read_bank,
    output logic                    read_active,
    output logic                    read_last
);

    localparam tagmem_pkg::word_count_t FULL = tagmem_pkg::word_count_t'(BANK_DEPTH);

    tagmem_pkg::word_count_t epc_fill;
    tagmem_pkg::word_count_t s1_fill;
    tagmem_pkg::word_count_t s2_fill;
    tagmem_pkg::word_count_t cmd_fill;   // fill of the bank named by the command
    tagmem_pkg::word_count_t step_fill;  // fill of the bank being written
    tagmem_pkg::word_count_t epc_top;
    tagmem_pkg::word_count_t remaining;

    assign cmd_fill  = (sensor_id == tagmem_pkg::SENSOR_1) ? s1_fill : s2_fill;
    assign step_fill = (written_sensor == tagmem_pkg::SENSOR_1) ? s1_fill : s2_fill;
    assign epc_top   = tagmem_pkg::word_count_t'(read_ptr) + read_words - 7'd1;

    assign epc_wr_addr = tagmem_pkg::mem_addr_t'(epc_fill);
    assign s1_wr_addr  = tagmem_pkg::mem_addr_t'(s1_fill);
    assign s2_wr_addr  = tagmem_pkg::mem_addr_t'(s2_fill);
    assign read_active = (remaining != '0);
    assign read_last   = (remaining == 7'd1);

    always_ff @(posedge clk) begin
        if (factory_reset) begin
            epc_fill  <= '0;
            s1_fill   <= '0;
            s2_fill   <= '0;
            remaining <= '0;
            read_bank <= tagmem_pkg::BANK_NONE;
        end else begin
            if (epc_written && epc_fill != FULL) epc_fill <= epc_fill + 7'd1;
            if (sensor_written && step_fill != FULL) begin
                if (written_sensor == tagmem_pkg::SENSOR_1) s1_fill <= s1_fill + 7'd1;
                else s2_fill <= s2_fill + 7'd1;
            end
            if (cmd_start) begin
                if (cmd_op == tagmem_pkg::CMD_READ_EPC) begin
                    read_addr <= tagmem_pkg::mem_addr_t'(epc_top);  // top word first
                    remaining <= read_words;
                    read_bank <= tagmem_pkg::BANK_EPC;
                end else begin
                    read_addr <= tagmem_pkg::mem_addr_t'(cmd_fill - 7'd1); // newest record
                    remaining <= cmd_fill;
                    read_bank <= (sensor_id == tagmem_pkg::SENSOR_1) ?
                                 tagmem_pkg::BANK_SENSOR1 : tagmem_pkg::BANK_SENSOR2;
                end
            end else if (read_step) begin
                read_addr <= read_addr - 6'd1;
                remaining <= remaining - 7'd1;
            end
        end
    end

    // the controller never completes a write into a full bank
    assert property (@(posedge clk) disable iff (factory_reset)
        !(epc_written && epc_fill == FULL) && !(sensor_written && step_fill == FULL));

endmodule

// ==== rtl/tagmem_pkg.sv ====
// word widths, address and count types, sensor record, command and bank codes
package tagmem_pkg;

    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;     // one memory word, also the EPC payload
    typedef logic [5:0]        mem_addr_t;
    typedef logic [6:0]        word_count_t; // 0 to 64

    typedef struct packed {
        logic [7:0] time_stamp;
        logic [7:0] sample;
    } sensor_record_t;

    typedef enum logic {
        SENSOR_1 = 1'b0,
        SENSOR_2 = 1'b1
    } sensor_id_t;

    // sensor write as queued, record tagged with its sensor
    typedef struct packed {
        sensor_id_t     id;
        sensor_record_t rec;
    } sensor_item_t;

    typedef enum logic {
        CMD_READ_EPC    = 1'b0,
        CMD_READ_SENSOR = 1'b1
    } cmd_op_t;

    typedef enum logic [2:0] {
        BANK_NONE    = 3'b000,
        BANK_EPC     = 3'b001,
        BANK_SENSOR1 = 3'b010,
        BANK_SENSOR2 = 3'b100
    } bank_sel_t;

endpackage

// ==== rtl/tagmem_top.sv ====
// write fifos, bank pointers, access controller and serializer
`timescale 1ns/10ps

module tagmem_top #(
    parameter int FIFO_DEPTH = 2,
    parameter int BANK_DEPTH = 64
) (
    input  logic                    clk,
    input  logic                    factory_reset,
    input  logic                    epc_valid,
    input  tagmem_pkg::word_t       epc_data,
    input  logic                    adc_valid,
    input  logic [7:0]              adc_sample,
    input  logic [7:0]              adc_time_stamp,
    input  tagmem_pkg::sensor_id_t  sensor_id,
    input  logic                    cmd_valid,
    input  tagmem_pkg::cmd_op_t     cmd_op,
    input  tagmem_pkg::mem_addr_t   read_ptr,
    input  tagmem_pkg::word_count_t read_words,
    input  tagmem_pkg::word_t       mem_read_data,
    output tagmem_pkg::word_t       mem_write_data,
    output tagmem_pkg::mem_addr_t   mem_addr,
    output tagmem_pkg::bank_sel_t   mem_sel,
    output logic                    pc_b,
    output logic                    we,
    output logic                    se,
    output logic                    tx_bit,
    output logic                    tx_bit_valid,
    output logic                    tx_done,
    output logic                    busy
);

    tagmem_pkg::sensor_item_t adc_item, sensor_item;
    tagmem_pkg::word_t        epc_head, word_data;
    tagmem_pkg::mem_addr_t    epc_wr_addr, s1_wr_addr, s2_wr_addr, read_addr;
    tagmem_pkg::bank_sel_t    read_bank;
    tagmem_pkg::sensor_id_t   written_sensor;
    logic epc_empty, epc_pop, sensor_empty, sensor_pop;
    logic cmd_start, epc_written, sensor_written, read_step, read_active, read_last;
    logic word_req, word_load, word_last, end_mark;

    assign adc_item = {sensor_id, adc_time_stamp, adc_sample}; // stamp above sample

    write_fifo #(.payload_t(tagmem_pkg::word_t), .DEPTH(FIFO_DEPTH)) epc_fifo (
        .clk, .factory_reset, .push(epc_valid), .push_data(epc_data), .pop(epc_pop),
        .pop_data(epc_head), .empty(epc_empty), .full());

    write_fifo #(.payload_t(tagmem_pkg::sensor_item_t), .DEPTH(FIFO_DEPTH)) sensor_fifo (
        .clk, .factory_reset, .push(adc_valid), .push_data(adc_item), .pop(sensor_pop),
        .pop_data(sensor_item), .empty(sensor_empty), .full());

    bank_pointers #(.BANK_DEPTH(BANK_DEPTH)) u_pointers (
        .clk, .factory_reset, .cmd_start, .cmd_op, .read_ptr, .read_words, .sensor_id,
        .epc_written, .sensor_written, .written_sensor, .read_step, .epc_wr_addr,
        .s1_wr_addr, .s2_wr_addr, .read_addr, .read_bank, .read_active, .read_last);

    access_ctrl u_ctrl (
        .clk, .factory_reset, .cmd_valid, .busy, .cmd_start, .epc_empty,
        .epc_data(epc_head), .epc_pop, .sensor_empty, .sensor_item, .sensor_pop,
        .epc_wr_addr, .s1_wr_addr, .s2_wr_addr, .read_addr, .read_bank, .read_active,
        .read_last, .epc_written, .sensor_written, .written_sensor, .read_step, .word_req,
        .word_load, .word_data, .word_last, .end_mark, .tx_done, .pc_b, .we, .se, .mem_sel,
        .mem_addr, .mem_write_data, .mem_read_data);

    tx_serializer u_tx (
        .clk, .factory_reset, .word_load, .word_data, .word_last, .end_mark, .word_req,
        .tx_bit, .tx_bit_valid, .tx_done);

endmodule

// ==== rtl/tx_serializer.sv ====
// one-word prefetch buffer and msb-first shift register with done pulse
`timescale 1ns/10ps

module tx_serializer (
    input  logic              clk,
    input  logic              factory_reset,
    input  logic              word_load,
    input  tagmem_pkg::word_t word_data,
    input  logic              word_last,
    input  logic              end_mark,
    output logic              word_req,
    output logic              tx_bit,
    output logic              tx_bit_valid,
    output logic              tx_done
);

    localparam int CNT_W = $clog2(tagmem_pkg::WORD_W + 1);

    tagmem_pkg::word_t buf_q;
    tagmem_pkg::word_t shift_q;
    logic              buf_full;
    logic [CNT_W-1:0]  bit_cnt;     // bits left in shift_q
    logic              last_seen;   // final word already fetched
    logic              end_seen;
    logic              shift_free;

    assign shift_free   = (bit_cnt <= CNT_W'(1));
    assign word_req     = !buf_full && !last_seen;
    assign tx_bit_valid = (bit_cnt != '0);
    assign tx_bit       = tx_bit_valid && shift_q[tagmem_pkg::WORD_W-1];

    always_ff @(posedge clk) begin
        if (factory_reset) begin
            buf_full  <= 1'b0;
            bit_cnt   <= '0;
            last_seen <= 1'b0;
            end_seen  <= 1'b0;
            tx_done   <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (word_load) begin    // only arrives while buffer is empty
                buf_q    <= word_data;
                buf_full <= 1'b1;
                if (word_last) last_seen <= 1'b1;
            end
            if (buf_full && shift_free) begin
                shift_q  <= buf_q;   // no gap bit between words
                bit_cnt  <= CNT_W'(tagmem_pkg::WORD_W);
                buf_full <= 1'b0;
            end else if (bit_cnt != '0) begin
                shift_q <= shift_q << 1;
                bit_cnt <= bit_cnt - 1'b1;
            end
            if (end_mark) end_seen <= 1'b1;
            if (end_seen && !buf_full && bit_cnt == '0) begin
                tx_done   <= 1'b1;
                end_seen  <= 1'b0;
                last_seen <= 1'b0;
            end
        end
    end

endmodule

// ==== rtl/write_fifo.sv ====
// small circular buffer for pending bank writes that drops pushes when full
`timescale 1ns/10ps

module write_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     factory_reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push  = push && !full;   // overflow drops the new payload
    assign do_pop   = pop && !empty;
    assign empty    = (count == '0);
    assign full     = (count == (PTR_W+1)'(DEPTH));
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (factory_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
        end
    end

    // controller only pops what it has seen queued
    assert property (@(posedge clk) disable iff (factory_reset) pop |-> !empty);

    // a dropped push leaves the slot it would have hit untouched
    assert property (@(posedge clk) disable iff (factory_reset)
        (push && full) |=> mem[$past(wr_ptr)] == $past(mem[wr_ptr]));

endmodule

// ==== run.sh ====
#!/bin/sh
# build tb_tagmem with Verilator from the project root, run it, scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_tagmem \
    -f flist.f --Mdir obj_dir -o tb_tagmem_sim
if [ $? -ne 0 ]; then
    echo "run.sh: compile step failed"
    exit 1
fi

./obj_dir/tb_tagmem_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "run.sh: simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "run.sh: simulator exited with status $sim_status"
    exit 1
fi
echo "run.sh: simulation finished without failure"
exit 0

// ==== tb/tagmem_tests.txt ====
# E epc_word | S id stamp sample | B epc_word id stamp sample epc_word2 (first two strobes share a cycle)
# R ptr count words | Q id count words; expected words in send order, newest first; all fields hex
Q 1 0
E 3000
E 1a2b
E c4d5
R 0 3 c4d5 1a2b 3000
S 0 01 7f
S 1 02 80
E 0e11
R 1 3 0e11 c4d5 1a2b
S 0 03 81
Q 0 2 0381 017f
Q 1 1 0280
B 5566 1 04 82 7788
R 4 2 7788 5566
Q 1 2 0482 0280
R 0 0
E 9abc
S 0 05 83
E def0
R 5 3 def0 9abc 7788
S 0 06 84
Q 0 4 0684 0583 0381 017f
B a1a2 0 07 85 b3b4
R 0 a b3b4 a1a2 def0 9abc 7788 5566 0e11 c4d5 1a2b 3000
Q 0 5 0785 0684 0583 0381 017f
Q 1 2 0482 0280
R 9 1 b3b4
R 2 2 0e11 c4d5

// ==== tb/tb_tagmem.sv ====
// testbench for tagmem_top with bank memory model, test file reader, LCG gaps and checks
`timescale 1ns/10ps

module tb_tagmem;

    localparam int WAIT_LIMIT = 200;    // cycles
    localparam int READ_LIMIT = 3000;

    logic clk, factory_reset, epc_valid, adc_valid, cmd_valid;
    logic pc_b, we, se, tx_bit, tx_bit_valid, tx_done, busy;
    logic we_d = 1'b0;
    logic [7:0]              adc_sample, adc_time_stamp;
    tagmem_pkg::word_t       epc_data, mem_read_data, mem_write_data;
    tagmem_pkg::sensor_id_t  sensor_id;
    tagmem_pkg::cmd_op_t     cmd_op;
    tagmem_pkg::mem_addr_t   read_ptr, mem_addr;
    tagmem_pkg::word_count_t read_words;
    tagmem_pkg::bank_sel_t   mem_sel;

    tagmem_pkg::word_t      epc_mem [64];
    tagmem_pkg::word_t      s1_mem [64];
    tagmem_pkg::word_t      s2_mem [64];
    tagmem_pkg::word_t      epc_q [$];      // EPC words not yet in memory
    tagmem_pkg::word_t      rec_q [$];
    tagmem_pkg::sensor_id_t rec_id_q [$];
    tagmem_pkg::word_t      read_q [$];     // expected words of the current read
    int epc_cnt = 0;
    int s1_cnt = 0;
    int s2_cnt = 0;
    int unsigned lcg_state = 32'd69889;

    tagmem_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory model with a fill pattern over the whole address
    initial begin
        for (int i = 0; i < 64; i++) begin
            epc_mem[i] = 16'he000 | 16'(i);
            s1_mem[i]  = 16'h5100 | 16'(i);
            s2_mem[i]  = 16'h5200 | 16'(i);
        end
    end

    always @(posedge we) begin
        case (mem_sel)
            tagmem_pkg::BANK_EPC:     epc_mem[mem_addr] = mem_write_data;
            tagmem_pkg::BANK_SENSOR1: s1_mem[mem_addr] = mem_write_data;
            tagmem_pkg::BANK_SENSOR2: s2_mem[mem_addr] = mem_write_data;
            default: ;
        endcase
    end

    always_comb begin
        mem_read_data = '0;
        if (se) begin
            case (mem_sel)
                tagmem_pkg::BANK_EPC:     mem_read_data = epc_mem[mem_addr];
                tagmem_pkg::BANK_SENSOR1: mem_read_data = s1_mem[mem_addr];
                tagmem_pkg::BANK_SENSOR2: mem_read_data = s2_mem[mem_addr];
                default:                  mem_read_data = '0;
            endcase
        end
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input tagmem_pkg::word_t got,
                              input tagmem_pkg::word_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR at %0t: %s is %h, expected %h",
                                        $time, name, got, exp));
    endtask

    task automatic check_bank(input string name, input tagmem_pkg::bank_sel_t got,
                              input tagmem_pkg::bank_sel_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR at %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input tagmem_pkg::word_count_t got,
                               input tagmem_pkg::word_count_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR at %0t: %s is %0d, expected %0d",
                                        $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("ERROR at %0t: %s is %b, expected %b",
                                        $time, name, got, exp));
    endtask

    // each write must land at the next free address of its bank
    task automatic note_write_landed();
        tagmem_pkg::sensor_id_t id;
        if (mem_sel == tagmem_pkg::BANK_EPC) begin
            if (epc_q.size() == 0) stop_with_failure("EPC bank written with no EPC write pending");
            check_word("epc_mem", epc_mem[epc_cnt], epc_q.pop_front());
            epc_cnt++;
        end else begin
            if (rec_q.size() == 0) stop_with_failure("sensor bank written with nothing pending");
            id = rec_id_q.pop_front();
            check_bank("mem_sel", mem_sel, (id == tagmem_pkg::SENSOR_1) ?
                       tagmem_pkg::BANK_SENSOR1 : tagmem_pkg::BANK_SENSOR2);
            if (id == tagmem_pkg::SENSOR_1) begin
                check_word("s1_mem", s1_mem[s1_cnt], rec_q.pop_front());
                s1_cnt++;
            end else begin
                check_word("s2_mem", s2_mem[s2_cnt], rec_q.pop_front());
                s2_cnt++;
            end
        end
    endtask

    always @(negedge clk) begin
        if (we_d && !we) note_write_landed();  // end of a write
        we_d = we;
    end

    function automatic int next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % 32'd6);
    endfunction

    task automatic send_epc(input tagmem_pkg::word_t w);
        @(posedge clk);
        epc_valid <= 1'b1;
        epc_data  <= w;
        epc_q.push_back(w);
        @(posedge clk);
        epc_valid <= 1'b0;
    endtask

    task automatic send_sensor(input tagmem_pkg::sensor_id_t id, input logic [7:0] stamp,
                               input logic [7:0] sample);
        @(posedge clk);
        adc_valid      <= 1'b1;
        sensor_id      <= id;
        adc_time_stamp <= stamp;
        adc_sample     <= sample;
        rec_id_q.push_back(id);
        rec_q.push_back({stamp, sample});   // stamp in the upper byte
        @(posedge clk);
        adc_valid <= 1'b0;
    endtask

    // EPC and sensor strobes in one cycle, then a second EPC strobe right behind
    task automatic send_burst(input tagmem_pkg::word_t first, input tagmem_pkg::sensor_id_t id,
                              input logic [7:0] stamp, input logic [7:0] sample,
                              input tagmem_pkg::word_t second);
        @(posedge clk);
        epc_valid      <= 1'b1;
        epc_data       <= first;
        adc_valid      <= 1'b1;
        sensor_id      <= id;
        adc_time_stamp <= stamp;
        adc_sample     <= sample;
        epc_q.push_back(first);
        epc_q.push_back(second);
        rec_id_q.push_back(id);
        rec_q.push_back({stamp, sample});
        @(posedge clk);
        adc_valid <= 1'b0;
        epc_data  <= second;
        @(posedge clk);
        epc_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        for (int t = 0; epc_q.size() != 0 || rec_q.size() != 0; t++) begin
            if (t == WAIT_LIMIT) stop_with_failure("timeout: queued writes never reached memory");
            @(negedge clk);
        end
    endtask

    task automatic wait_not_busy();
        for (int t = 0; busy; t++) begin
            if (t == WAIT_LIMIT) stop_with_failure("timeout: busy stayed high");
            @(negedge clk);
        end
    endtask

    task automatic run_read(input tagmem_pkg::cmd_op_t op, input tagmem_pkg::mem_addr_t ptr,
                            input tagmem_pkg::word_count_t count,
                            input tagmem_pkg::sensor_id_t id);
        tagmem_pkg::word_t shreg;
        int nbits;
        int nwords;
        shreg  = '0;
        nbits  = 0;
        nwords = 0;
        wait_drained();
        wait_not_busy();
        @(posedge clk);
        cmd_valid  <= 1'b1;
        cmd_op     <= op;
        read_ptr   <= ptr;
        read_words <= count;
        sensor_id  <= id;
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        check_bit("busy", busy, 1'b1);
        for (int t = 0; !tx_done; t++) begin
            if (t == READ_LIMIT) stop_with_failure("timeout: read did not end with tx_done");
            @(negedge clk);
            if (tx_bit_valid) begin
                shreg = {shreg[tagmem_pkg::WORD_W-2:0], tx_bit};   // msb arrives first
                nbits++;
                if (nbits == tagmem_pkg::WORD_W) begin
                    if (read_q.size() == 0) stop_with_failure("read sent more words than expected");
                    check_word("tx word", shreg, read_q.pop_front());
                    nbits = 0;
                    nwords++;
                end
            end
        end
        check_bit("tx_bit_valid", tx_bit_valid, 1'b0);
        check_bit("busy", busy, 1'b0);      // falls together with tx_done
        check_count("words sent", tagmem_pkg::word_count_t'(nwords), count);
        check_count("bits past the last word", tagmem_pkg::word_count_t'(nbits), '0);
    endtask

    initial begin
        int fd;
        int r;
        int a;
        int b;
        int c;
        int d;
        int e;
        int n;
        logic [7:0]       op_ch;
        logic [8*120-1:0] line;
        factory_reset  = 1'b1;
        epc_valid      = 1'b0;
        epc_data       = '0;
        adc_valid      = 1'b0;
        adc_sample     = '0;
        adc_time_stamp = '0;
        sensor_id      = tagmem_pkg::SENSOR_1;
        cmd_valid      = 1'b0;
        cmd_op         = tagmem_pkg::CMD_READ_EPC;
        read_ptr       = '0;
        read_words     = '0;
        repeat (2) @(posedge clk);
        factory_reset <= 1'b0;
        @(negedge clk);
        check_bit("pc_b", pc_b, 1'b1);
        check_bit("we", we, 1'b0);
        check_bit("se", se, 1'b0);
        check_bit("tx_bit_valid", tx_bit_valid, 1'b0);
        check_bit("busy", busy, 1'b0);
        check_bank("mem_sel", mem_sel, tagmem_pkg::BANK_NONE);

        fd = $fopen("tb/tagmem_tests.txt", "r");
        if (fd == 0) stop_with_failure("could not open tb/tagmem_tests.txt");
        while ($fscanf(fd, " %c", op_ch) == 1) begin
            case (op_ch)
                "#": r = $fgets(line, fd);     // column notes
                "E": begin
                    r = $fscanf(fd, "%h", a);
                    send_epc(tagmem_pkg::word_t'(a));
                end
                "S": begin
                    r = $fscanf(fd, "%h %h %h", a, b, c);
                    send_sensor(tagmem_pkg::sensor_id_t'(a[0]), b[7:0], c[7:0]);
                end
                "B": begin
                    r = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    send_burst(tagmem_pkg::word_t'(a), tagmem_pkg::sensor_id_t'(b[0]),
                               c[7:0], d[7:0], tagmem_pkg::word_t'(e));
                end
                "R", "Q": begin
                    r = $fscanf(fd, "%h %h", a, n);
                    if (r != 2) stop_with_failure("read line in the test file is malformed");
                    for (int i = 0; i < n; i++) begin
                        r = $fscanf(fd, "%h", b);
                        read_q.push_back(tagmem_pkg::word_t'(b));
                    end
                    if (op_ch == "R")
                        run_read(tagmem_pkg::CMD_READ_EPC, tagmem_pkg::mem_addr_t'(a),
                                 tagmem_pkg::word_count_t'(n), tagmem_pkg::SENSOR_1);
                    else
                        run_read(tagmem_pkg::CMD_READ_SENSOR, '0,
                                 tagmem_pkg::word_count_t'(n), tagmem_pkg::sensor_id_t'(a[0]));
                end
                default: stop_with_failure("unknown operation in the test file");
            endcase
            repeat (next_gap()) @(posedge clk);
        end
        $fclose(fd);
        wait_drained();
        wait_not_busy();
        $display("TB PASSED");
        $finish;
    end

endmodule
